// File: Bender.yml
package:
  name: linebuf

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/linebuf_pkg.sv
      - verilog/mem_sp.sv
      - verilog/linebuf_ctrl.sv
      - verilog/linebuf_counter.sv
      - verilog/linebuf_window.sv
      - verilog/linebuf_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/linebuf_chk.sv
      - bench/linebuf_monitor.sv
      - bench/tb_linebuf.sv

// File: bench/linebuf_chk.sv
`timescale 1ns/1ns
`include "linebuf_cfg.svh"

module linebuf_chk (
  input logic                   clk,
  input logic                   xrst,
  input logic                   buf_en,
  input linebuf_pkg::lb_state_t state,
  input logic                   win_valid,
  input logic                   charge_end,
  input logic                   active_end,
  input logic [`LB_MAXLINE:0]   bank_sel
);
  import linebuf_pkg::*;

  int assert_errors = 0;

  // ========================================
  // control properties
  // ========================================

  a_start: assert property (@(posedge clk) disable iff (!xrst)
    (state == LB_WAIT && buf_en) |=> (state == LB_CHARGE))
    else begin
      $error("buf_en in wait did not lead to charge");
      assert_errors++;
    end

  // win_valid trails the active read by the ram and shift latency
  a_valid: assert property (@(posedge clk) disable iff (!xrst)
    win_valid |-> ($past(state, 2) == LB_ACTIVE))
    else begin
      $error("win_valid without an active read two cycles before");
      assert_errors++;
    end

  a_bank: assert property (@(posedge clk) disable iff (!xrst) $onehot0(bank_sel))
    else begin
      $error("bank_sel has more than one bank enabled");
      assert_errors++;
    end

  a_ends: assert property (@(posedge clk) disable iff (!xrst) !(charge_end && active_end))
    else begin
      $error("charge_end and active_end high together");
      assert_errors++;
    end

endmodule

bind linebuf_top linebuf_chk u_chk (
  .clk        (clk),
  .xrst       (xrst),
  .buf_en     (buf_en),
  .state      (state),
  .win_valid  (win_valid),
  .charge_end (charge_end),
  .active_end (active_end),
  .bank_sel   (bank_sel)
);

// File: bench/linebuf_input.txt
// per frame: img_size fil_size pad_size sum_count, then the padded pixels row by row,
// then one expected window sum per win_valid cycle; a header of zeros ends the file
// frame 1, 4x4 image, filter 3, no padding
4 3 0 3
0 1 2 3
10 11 12 13
20 21 22 23
30 31 32 33
99 a2 129
// frame 2, 3x3 image, filter 3, padding 1
3 3 1 8
0 0 0 0 0
0 1 2 3 0
0 4 fffb 6 0
0 7 8 9 0
0 0 0 0 0
2 b 6 11 23 17 e 1d
// frame 3, 6x6 image, filter 5, no padding
6 5 0 3
0 1 2 3 4 5
10 11 12 13 14 15
20 21 22 23 24 25
30 31 32 33 34 35
40 41 42 43 44 45
50 51 52 53 54 55
352 36b 4e2
0 0 0 0

// File: bench/linebuf_monitor.sv
`timescale 1ns/1ns
`include "linebuf_cfg.svh"

module linebuf_monitor #(
  localparam int N  = `LB_MAXLINE,
  localparam int DW = `LB_DWIDTH
) (
  input logic                   clk,
  input logic                   xrst,
  input logic                   buf_en,
  input logic [`LB_LWIDTH-1:0]  img_size,
  input logic [`LB_LWIDTH-1:0]  fil_size,
  input logic [`LB_LWIDTH-1:0]  pad_size,
  input logic signed [DW-1:0]   buf_input,
  input logic signed [DW-1:0]   buf_output [N*N-1:0],
  input logic                   busy,
  input logic                   win_valid
);

  logic [31:0]          data [512];
  logic signed [DW-1:0] img [`LB_MAXSIZE*`LB_MAXSIZE];
  int   value_errors;
  int   other_errors;
  int   fptr;
  int   sptr;
  int   nsum;
  int   nwin;
  int   w;
  int   fil;
  int   cur_r;
  int   cur_c;
  int   bcount;
  int   exp_busy;
  logic started;
  logic frame_open;
  logic was_busy;
  logic rise_pending;

  initial begin
    $readmemh("bench/linebuf_input.txt", data);
    value_errors = 0;
    other_errors = 0;
    fptr         = 0;
    started      = 1'b0;
    frame_open   = 1'b0;
    was_busy     = 1'b0;
    rise_pending = 1'b0;
  end

  // ========================================
  // frame bookkeeping
  // ========================================

  task automatic close_frame();
    if (frame_open) begin
      if (nwin != nsum) begin
        $display("frame ended with %0d windows, the data file has %0d sums", nwin, nsum);
        other_errors++;
      end
      frame_open = 1'b0;
    end
  endtask

  task automatic open_frame();
    fil  = int'(data[fptr+1]);
    w    = int'(data[fptr]) + 2 * int'(data[fptr+2]);
    nsum = int'(data[fptr+3]);
    if (img_size != data[fptr][7:0] || fil_size != data[fptr+1][7:0] ||
        pad_size != data[fptr+2][7:0]) begin
      $display("size inputs at buf_en do not match the frame header");
      other_errors++;
    end
    sptr         = fptr + 4 + w * w;
    fptr         = sptr + nsum;
    nwin         = 0;
    cur_r        = fil - 1;
    cur_c        = fil - 1;
    bcount       = 0;
    exp_busy     = w * (w + 1);
    frame_open   = 1'b1;
    rise_pending = 1'b1;
  endtask

  // windows come in raster order of their bottom-right pixel
  task automatic check_window();
    int                   sum;
    int                   exp_sum;
    int                   r0;
    int                   c0;
    logic signed [DW-1:0] got;
    logic signed [DW-1:0] exp;
    if (!frame_open || nwin >= nsum) begin
      $display("win_valid high with no window expected");
      other_errors++;
      return;
    end
    r0  = cur_r - fil + 1;
    c0  = cur_c - fil + 1;
    sum = 0;
    for (int i = 0; i < fil; i++) begin
      for (int j = 0; j < fil; j++) begin
        got = buf_output[N*i + N - fil + j];
        exp = img[(r0 + i) * w + c0 + j];
        if (got !== exp) begin
          $display("CHECK FAILED buf_output[%0d] in window %0d: expected %h, got %h",
                   N*i + N - fil + j, nwin, exp, got);
          value_errors++;
        end
        sum += got;
      end
    end
    exp_sum = $signed(data[sptr+nwin]);
    if (sum != exp_sum) begin
      $display("CHECK FAILED window sum %0d: expected %h, got %h", nwin, exp_sum, sum);
      value_errors++;
    end
    nwin++;
    if (cur_c < w - 1) begin
      cur_c++;
    end else begin
      cur_r++;
      cur_c = fil - 1;
    end
  endtask

  // ========================================
  // per-cycle checks
  // ========================================

  always @(posedge clk) begin
    if (xrst) begin
      if (!started) begin
        if (busy !== 1'b0) begin
          $display("CHECK FAILED busy after reset: expected %h, got %h",
                   1'b0, busy);
          value_errors++;
        end
        if (win_valid !== 1'b0) begin
          $display("CHECK FAILED win_valid after reset: expected %h, got %h",
                   1'b0, win_valid);
          value_errors++;
        end
        for (int k = 0; k < N*N; k++) begin
          if (buf_output[k] !== '0) begin
            $display("CHECK FAILED buf_output[%0d] after reset: expected %h, got %h",
                     k, 16'h0, buf_output[k]);
            value_errors++;
          end
        end
      end
      if (rise_pending) begin
        rise_pending = 1'b0;
        if (busy !== 1'b1) begin
          $display("CHECK FAILED busy one cycle after buf_en: expected %h, got %h",
                   1'b1, busy);
          value_errors++;
        end
      end
      if (busy === 1'b1 && frame_open) begin
        if (bcount < w * w) begin
          img[bcount] = buf_input;
        end
        bcount++;
      end
      if (was_busy && busy !== 1'b1 && frame_open && bcount != exp_busy) begin
        $display("CHECK FAILED busy cycles: expected %h, got %h", exp_busy, bcount);
        value_errors++;
      end
      if (win_valid === 1'b1) begin
        check_window();
      end
      if (buf_en === 1'b1 && busy !== 1'b1) begin
        close_frame();
        started = 1'b1;
        open_frame();
      end
      was_busy = (busy === 1'b1);
    end
  end

endmodule

// File: bench/tb_linebuf.sv
`timescale 1ns/1ns
`include "linebuf_cfg.svh"

module tb_linebuf;

  logic                         clk;
  logic                         xrst;
  logic                         buf_en;
  logic [`LB_LWIDTH-1:0]        img_size;
  logic [`LB_LWIDTH-1:0]        fil_size;
  logic [`LB_LWIDTH-1:0]        pad_size;
  logic signed [`LB_DWIDTH-1:0] buf_input;
  logic signed [`LB_DWIDTH-1:0] buf_output [`LB_MAXLINE*`LB_MAXLINE-1:0];
  logic                         busy;
  logic                         win_valid;

  logic [31:0] stim [512];
  int          limit;
  int          cycles;
  int          p;
  int          w;
  int          npix;
  int          gap;
  int          total;

  linebuf_top u_dut (
    .clk        (clk),
    .xrst       (xrst),
    .buf_en     (buf_en),
    .img_size   (img_size),
    .fil_size   (fil_size),
    .pad_size   (pad_size),
    .buf_input  (buf_input),
    .buf_output (buf_output),
    .busy       (busy),
    .win_valid  (win_valid)
  );

  linebuf_monitor u_mon (
    .clk        (clk),
    .xrst       (xrst),
    .buf_en     (buf_en),
    .img_size   (img_size),
    .fil_size   (fil_size),
    .pad_size   (pad_size),
    .buf_input  (buf_input),
    .buf_output (buf_output),
    .busy       (busy),
    .win_valid  (win_valid)
  );

  function automatic int frame_width(int idx);
    return int'(stim[idx]) + 2 * int'(stim[idx+2]);
  endfunction

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ========================================
  // timeout
  // ========================================

  initial begin
    cycles = 0;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("run stopped after %0d cycles without finishing", cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  // ========================================
  // stimulus
  // ========================================

  initial begin
    void'($urandom(32'h19d41757));
    xrst      = 1'b0;
    buf_en    = 1'b0;
    img_size  = '0;
    fil_size  = '0;
    pad_size  = '0;
    buf_input = '0;
    $readmemh("bench/linebuf_input.txt", stim);

    // frame length, worst gap and a margin per frame
    limit = 116;
    p     = 0;
    while (stim[p] != 32'd0) begin
      w     = frame_width(p);
      limit = limit + w * (w + 1) + 12;
      p     = p + 4 + w * w + int'(stim[p+3]);
    end

    repeat (2) @(posedge clk);
    xrst <= 1'b1;
    repeat (4) @(posedge clk);

    p = 0;
    while (stim[p] != 32'd0) begin
      w        = frame_width(p);
      npix     = w * w;
      img_size <= stim[p][7:0];
      fil_size <= stim[p+1][7:0];
      pad_size <= stim[p+2][7:0];
      buf_en   <= 1'b1;
      for (int n = 0; n < npix; n++) begin
        @(posedge clk);
        // a second strobe inside the frame must be ignored
        buf_en    <= (n == 5);
        buf_input <= stim[p+4+n][15:0];
      end
      @(posedge clk);
      buf_input <= '0;
      do @(negedge clk); while (busy);
      gap = 1 + ($urandom % 8);
      repeat (gap) @(posedge clk);
      p = p + 4 + npix + int'(stim[p+3]);
    end

    repeat (10) @(posedge clk);
    u_mon.close_frame();
    total = u_mon.value_errors + u_mon.other_errors + u_dut.u_chk.assert_errors;
    $display("errors: value %0d, other %0d, assertion %0d",
             u_mon.value_errors, u_mon.other_errors, u_dut.u_chk.assert_errors);
    if (total == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+verilog
verilog/linebuf_pkg.sv
verilog/mem_sp.sv
verilog/linebuf_ctrl.sv
verilog/linebuf_counter.sv
verilog/linebuf_window.sv
verilog/linebuf_top.sv
bench/linebuf_chk.sv
bench/linebuf_monitor.sv
bench/tb_linebuf.sv

// File: verilog/linebuf_cfg.svh
`ifndef LINEBUF_CFG_SVH
`define LINEBUF_CFG_SVH

// ========================================
// data and size widths
// ========================================

// signed pixel
`define LB_DWIDTH 16
// img_size, fil_size and pad_size inputs
`define LB_LWIDTH 8

// ========================================
// buffer geometry
// ========================================

// largest filter, also the window edge
`define LB_MAXLINE 5
// longest padded line, 32 pixels plus 2x2 padding
`define LB_MAXSIZE 36

`endif

// File: verilog/linebuf_counter.sv
`timescale 1ns/1ns
`include "linebuf_cfg.svh"

module linebuf_counter #(
  localparam int AWIDTH = $clog2(`LB_MAXSIZE + 1),
  localparam int CWIDTH = $clog2(`LB_MAXLINE + 1) + 1,
  localparam int NBANK  = `LB_MAXLINE + 1
) (
  input  logic                   clk,
  input  logic                   xrst,
  input  linebuf_pkg::lb_state_t state,
  input  logic [`LB_LWIDTH-1:0]  img_size,
  input  logic [`LB_LWIDTH-1:0]  fil_size,
  input  logic [`LB_LWIDTH-1:0]  pad_size,
  output logic [AWIDTH-1:0]      col_addr,
  output logic [NBANK-1:0]       bank_sel,
  output logic [CWIDTH-1:0]      win_sel,
  output logic                   charge_end,
  output logic                   active_end
);
  import linebuf_pkg::*;

  logic [AWIDTH-1:0] pad_width;
  logic [AWIDTH-1:0] col_last;
  logic [CWIDTH-1:0] bank_cnt;
  logic [AWIDTH-1:0] line_cnt;
  logic              run;
  logic              col_wrap;

  // padded line length
  assign pad_width = AWIDTH'((pad_size << 1) + img_size);
  assign col_last  = pad_width - AWIDTH'(1);
  assign run       = (state == LB_CHARGE) || (state == LB_ACTIVE);
  assign col_wrap  = (col_addr == col_last);

  assign charge_end = (state == LB_CHARGE) &&
                      (bank_cnt == CWIDTH'(fil_size - 1'b1)) &&
                      (col_addr == AWIDTH'(img_size - 1'b1));

  // w+1 lines, the last pixel lands at column 0 of line w
  assign active_end = (state == LB_ACTIVE) && (line_cnt == pad_width) && col_wrap;

  assign bank_sel = run ? (NBANK'(1) << bank_cnt) : '0;

  // ========================================
  // column, bank and line counters
  // ========================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      col_addr <= '0;
      bank_cnt <= '0;
      line_cnt <= '0;
    end else if (state == LB_WAIT) begin
      col_addr <= '0;
      bank_cnt <= '0;
      line_cnt <= '0;
    end else if (run) begin
      if (col_wrap) begin
        col_addr <= '0;
        bank_cnt <= (bank_cnt == CWIDTH'(`LB_MAXLINE)) ? '0 : bank_cnt + 1'b1;
        line_cnt <= (line_cnt == pad_width) ? '0 : line_cnt + 1'b1;
      end else begin
        col_addr <= col_addr + 1'b1;
      end
    end
  end

  // ========================================
  // row select
  // ========================================

  // 0 gives zero rows, k+1 maps window row i to bank (i+k) mod 6
  // restarts when the bank counter comes round to fil_size again
  always_ff @(posedge clk) begin
    if (!xrst) begin
      win_sel <= '0;
    end else if (state == LB_WAIT) begin
      win_sel <= '0;
    end else if (state == LB_ACTIVE && col_addr == '0) begin
      if (bank_cnt == CWIDTH'(fil_size)) begin
        win_sel <= CWIDTH'(1);
      end else begin
        win_sel <= win_sel + 1'b1;
      end
    end
  end

endmodule

// File: verilog/linebuf_ctrl.sv
`timescale 1ns/1ns
`include "linebuf_cfg.svh"

module linebuf_ctrl #(
  localparam int AWIDTH = $clog2(`LB_MAXSIZE + 1)
) (
  input  logic                   clk,
  input  logic                   xrst,
  input  logic                   buf_en,
  input  logic                   charge_end,
  input  logic                   active_end,
  input  logic [AWIDTH-1:0]      col_addr,
  input  logic [`LB_LWIDTH-1:0]  fil_size,
  output linebuf_pkg::lb_state_t state,
  output logic                   busy,
  output logic                   win_valid
);
  import linebuf_pkg::*;

  logic       row_seen;
  logic       win_cond;
  logic [1:0] valid_dly;

  // ========================================
  // frame state machine
  // ========================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= LB_WAIT;
    end else begin
      case (state)
        LB_WAIT: begin
          if (buf_en) begin
            state <= LB_CHARGE;
          end
        end
        LB_CHARGE: begin
          if (charge_end) begin
            state <= LB_ACTIVE;
          end
        end
        LB_ACTIVE: begin
          if (active_end) begin
            state <= LB_WAIT;
          end
        end
        default: state <= LB_WAIT;
      endcase
    end
  end

  assign busy = (state != LB_WAIT);

  // ========================================
  // window qualifier
  // ========================================

  // set at the first line start in active, the window rows hold image lines from then on
  always_ff @(posedge clk) begin
    if (!xrst) begin
      row_seen <= 1'b0;
    end else if (state == LB_WAIT) begin
      row_seen <= 1'b0;
    end else if (state == LB_ACTIVE && col_addr == '0) begin
      row_seen <= 1'b1;
    end
  end

  // column 0 reads the last pixel of the line before
  assign win_cond = (state == LB_ACTIVE) && row_seen &&
                    (col_addr == '0 || col_addr >= AWIDTH'(fil_size));

  // one cycle of ram read, one of window shift
  always_ff @(posedge clk) begin
    if (!xrst) begin
      valid_dly <= '0;
    end else begin
      valid_dly <= {valid_dly[0], win_cond};
    end
  end

  assign win_valid = valid_dly[1];

endmodule

// File: verilog/linebuf_pkg.sv
package linebuf_pkg;

  // frame phases
  // charge fills the first fil_size lines, active emits windows
  typedef enum logic [1:0] {
    LB_WAIT   = 2'd0,
    LB_CHARGE = 2'd1,
    LB_ACTIVE = 2'd2
  } lb_state_t;

endpackage

// File: verilog/linebuf_top.sv
`timescale 1ns/1ns
`include "linebuf_cfg.svh"

module linebuf_top #(
  localparam int AWIDTH = $clog2(`LB_MAXSIZE + 1),
  localparam int CWIDTH = $clog2(`LB_MAXLINE + 1) + 1,
  localparam int NBANK  = `LB_MAXLINE + 1
) (
  input  logic                         clk,
  input  logic                         xrst,
  input  logic                         buf_en,
  input  logic [`LB_LWIDTH-1:0]        img_size,
  input  logic [`LB_LWIDTH-1:0]        fil_size,
  input  logic [`LB_LWIDTH-1:0]        pad_size,
  input  logic signed [`LB_DWIDTH-1:0] buf_input,
  output logic signed [`LB_DWIDTH-1:0] buf_output [`LB_MAXLINE*`LB_MAXLINE-1:0],
  output logic                         busy,
  output logic                         win_valid
);
  import linebuf_pkg::*;

  lb_state_t         state;
  logic              charge_end;
  logic              active_end;
  logic [AWIDTH-1:0] col_addr;
  logic [NBANK-1:0]  bank_sel;
  logic [CWIDTH-1:0] win_sel;

  linebuf_ctrl u_ctrl (
    .clk        (clk),
    .xrst       (xrst),
    .buf_en     (buf_en),
    .charge_end (charge_end),
    .active_end (active_end),
    .col_addr   (col_addr),
    .fil_size   (fil_size),
    .state      (state),
    .busy       (busy),
    .win_valid  (win_valid)
  );

  linebuf_counter u_counter (
    .clk        (clk),
    .xrst       (xrst),
    .state      (state),
    .img_size   (img_size),
    .fil_size   (fil_size),
    .pad_size   (pad_size),
    .col_addr   (col_addr),
    .bank_sel   (bank_sel),
    .win_sel    (win_sel),
    .charge_end (charge_end),
    .active_end (active_end)
  );

  // window rows trail the line being written by one line
  linebuf_window u_window (
    .clk        (clk),
    .xrst       (xrst),
    .buf_input  (buf_input),
    .col_addr   (col_addr),
    .bank_sel   (bank_sel),
    .win_sel    (win_sel),
    .buf_output (buf_output)
  );

endmodule

// File: verilog/linebuf_window.sv
`timescale 1ns/1ns
`include "linebuf_cfg.svh"

module linebuf_window #(
  localparam int AWIDTH = $clog2(`LB_MAXSIZE + 1),
  localparam int CWIDTH = $clog2(`LB_MAXLINE + 1) + 1,
  localparam int NBANK  = `LB_MAXLINE + 1,
  localparam int N      = `LB_MAXLINE,
  localparam int DW     = `LB_DWIDTH
) (
  input  logic                 clk,
  input  logic                 xrst,
  input  logic signed [DW-1:0] buf_input,
  input  logic [AWIDTH-1:0]    col_addr,
  input  logic [NBANK-1:0]     bank_sel,
  input  logic [CWIDTH-1:0]    win_sel,
  output logic signed [DW-1:0] buf_output [N*N-1:0]
);

  logic signed [DW-1:0] pix_in;
  logic signed [DW-1:0] rd_data [NBANK];
  logic signed [DW-1:0] row_mux [N];
  logic signed [DW-1:0] pixel [N*N-1:0];

  // ========================================
  // line memories
  // ========================================

  always_ff @(posedge clk) begin
    pix_in <= buf_input;
  end

  for (genvar b = 0; b < NBANK; b++) begin : g_bank
    mem_sp #(
      .DWIDTH (DW),
      .AWIDTH (AWIDTH)
    ) u_mem (
      .clk       (clk),
      .mem_we    (bank_sel[b]),
      .mem_addr  (col_addr),
      .mem_wdata (pix_in),
      .mem_rdata (rd_data[b])
    );
  end

  // ========================================
  // row rotation and shift registers
  // ========================================

  for (genvar i = 0; i < N; i++) begin : g_row
    // oldest line on row 0
    always_comb begin
      row_mux[i] = '0;
      for (int k = 0; k < NBANK; k++) begin
        if (win_sel == CWIDTH'(k + 1)) begin
          row_mux[i] = rd_data[(i + k) % NBANK];
        end
      end
    end

    for (genvar j = 0; j < N; j++) begin : g_col
      if (j == N - 1) begin : g_load
        always_ff @(posedge clk) begin
          if (!xrst) begin
            pixel[N*i+j] <= '0;
          end else begin
            pixel[N*i+j] <= row_mux[i];
          end
        end
      end else begin : g_shift
        always_ff @(posedge clk) begin
          if (!xrst) begin
            pixel[N*i+j] <= '0;
          end else begin
            pixel[N*i+j] <= pixel[N*i+j+1];
          end
        end
      end
    end
  end

  assign buf_output = pixel;

endmodule

// File: verilog/mem_sp.sv
`timescale 1ns/1ns

module mem_sp #(
  parameter int DWIDTH = 16,
  parameter int AWIDTH = 6
) (
  input  logic                     clk,
  input  logic                     mem_we,
  input  logic [AWIDTH-1:0]        mem_addr,
  input  logic signed [DWIDTH-1:0] mem_wdata,
  output logic signed [DWIDTH-1:0] mem_rdata
);

  logic signed [DWIDTH-1:0] mem [2**AWIDTH];

  // registered read returns the old word on a write
  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_addr] <= mem_wdata;
    end
    mem_rdata <= mem[mem_addr];
  end

endmodule
